//--- c16_mem_glue.f
src/c16_bus_pkg.sv
src/c16_mem_pkg.sv
src/ted_bus_decoder.sv
src/download_injector.sv
src/zp_shadow.sv
src/sdram_port_mux.sv
src/reset_gen.sv
src/c16_mem_glue.sv
testbench/c16_mem_glue_assert.sv
testbench/tb_c16_mem_glue.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it, exit status is the verdict
verilator --binary --timing --assert -Wno-fatal -f c16_mem_glue.f \
	--top-module tb_c16_mem_glue -o tb_c16_mem_glue \
	&& ./obj_dir/tb_c16_mem_glue \
	|| { echo "simulation failed"; exit 1; }

//--- src/c16_bus_pkg.sv
package c16_bus_pkg;

	// ----------------------------------------------------------
	// TED memory bus
	// ----------------------------------------------------------

	// cpu address as seen after row/column demultiplexing
	typedef logic [15:0] c16_addr_t;

	// everything the core drives toward memory
	typedef struct packed {
		logic        ras_n;
		logic        cas_n;
		logic        rw;
		logic [7:0]  a;
		logic [7:0]  dout;
		logic        basic_sel_n;
		logic        kernal_sel_n;
		logic [13:0] rom_addr;
		logic [3:0]  rom_sel;
	} ted_bus_t;

	// rom bank, used as the upper bits of the rom region offset
	typedef enum logic [1:0] {
		KERNAL    = 2'b00,
		BASIC     = 2'b01,
		FUNC_LOW  = 2'b10,
		FUNC_HIGH = 2'b11
	} rom_bank_e;

	// ----------------------------------------------------------
	// zero page shadow pointers
	// ----------------------------------------------------------

	localparam int ZP_PTR_NUM = 4;

	// base (low byte) of each pointer, high byte sits at base+1
	localparam logic [ZP_PTR_NUM-1:0][15:0] ZP_PTR_ADDR = {
		16'h009d, 16'h0031, 16'h002f, 16'h002d
	};

endpackage

//--- src/c16_mem_glue.sv
`timescale 1ns/1ns

module c16_mem_glue #(
	parameter int LONG_RESET_CYCLES  = 28_000_000,
	parameter int SHORT_RESET_CYCLES = 65_536
) (
	input  logic                      clk28,
	input  logic                      pll_locked,
	input  c16_bus_pkg::ted_bus_t     ted_i,
	output logic [7:0]                c16_din_o,
	output logic                      c16_wait_o,
	output logic                      reset_o,
	input  logic                      memory_16k_i,
	input  logic                      reboot_i,
	input  logic                      reset_button_i,
	input  logic                      osd_reset_i,
	input  c16_mem_pkg::dl_session_t  dl_session_i,
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  c16_mem_pkg::mem_addr_t    wb_adr_i,
	input  logic [7:0]                wb_dat_i,
	output logic                      wb_ack_o,
	output c16_mem_pkg::sdram_req_t   sdram_req_o,
	input  logic [15:0]               sdram_dout_i,
	output logic                      clkref_o
);

	c16_bus_pkg::c16_addr_t                cpu_addr, prg_last_addr;
	c16_bus_pkg::rom_bank_e                rom_bank;
	c16_mem_pkg::sdram_req_t               io_req;
	logic [c16_mem_pkg::SLOT_BITS-1:0]     slot;
	logic                                  rom_access, cpu_wr, cpu_rd, cas_fall;
	logic                                  prg_end, zp_hit, rom_dl, prg_dl;
	logic [7:0]                            zp_dout;

	// ----------------------------------------------------------
	// download session decode
	// ----------------------------------------------------------

	assign rom_dl = dl_session_i.active &&
		((dl_session_i.index == c16_mem_pkg::DL_ROM_COMBINED) ||
		(dl_session_i.index == c16_mem_pkg::DL_KERNAL));
	assign prg_dl = dl_session_i.active && (dl_session_i.index == c16_mem_pkg::DL_PRG);

	// core is stalled while memory is being filled
	assign c16_wait_o = rom_dl || prg_dl;

	assign clkref_o = slot[c16_mem_pkg::SLOT_BITS-1];

	// ----------------------------------------------------------
	// blocks
	// ----------------------------------------------------------

	ted_bus_decoder u_ted_bus_decoder (
		.clk28        (clk28),
		.pll_locked   (pll_locked),
		.ted_i        (ted_i),
		.cpu_addr_o   (cpu_addr),
		.rom_access_o (rom_access),
		.rom_bank_o   (rom_bank),
		.cpu_wr_o     (cpu_wr),
		.cpu_rd_o     (cpu_rd),
		.cas_fall_o   (cas_fall),
		.slot_o       (slot)
	);

	download_injector u_download_injector (
		.clk28           (clk28),
		.pll_locked      (pll_locked),
		.dl_session_i    (dl_session_i),
		.wb_cyc_i        (wb_cyc_i),
		.wb_stb_i        (wb_stb_i),
		.wb_we_i         (wb_we_i),
		.wb_adr_i        (wb_adr_i),
		.wb_dat_i        (wb_dat_i),
		.wb_ack_o        (wb_ack_o),
		.io_req_o        (io_req),
		.prg_end_o       (prg_end),
		.prg_last_addr_o (prg_last_addr),
		.clkref_i        (clkref_o)
	);

	zp_shadow u_zp_shadow (
		.clk28           (clk28),
		.pll_locked      (pll_locked),
		.cpu_addr_i      (cpu_addr),
		.rom_access_i    (rom_access),
		.cpu_wr_i        (cpu_wr),
		.cas_fall_i      (cas_fall),
		.cpu_dout_i      (ted_i.dout),
		.prg_end_i       (prg_end),
		.prg_last_addr_i (prg_last_addr),
		.zp_hit_o        (zp_hit),
		.zp_dout_o       (zp_dout)
	);

	sdram_port_mux u_sdram_port_mux (
		.clkref_i     (clkref_o),
		.memory_16k_i (memory_16k_i),
		.cpu_addr_i   (cpu_addr),
		.rom_access_i (rom_access),
		.rom_bank_i   (rom_bank),
		.rom_addr_i   (ted_i.rom_addr),
		.cpu_wr_i     (cpu_wr),
		.cpu_rd_i     (cpu_rd),
		.cpu_dout_i   (ted_i.dout),
		.io_req_i     (io_req),
		.zp_hit_i     (zp_hit),
		.zp_dout_i    (zp_dout),
		.sdram_dout_i (sdram_dout_i),
		.sdram_req_o  (sdram_req_o),
		.c16_din_o    (c16_din_o)
	);

	reset_gen #(
		.LONG_RESET_CYCLES  (LONG_RESET_CYCLES),
		.SHORT_RESET_CYCLES (SHORT_RESET_CYCLES)
	) u_reset_gen (
		.clk28          (clk28),
		.pll_locked     (pll_locked),
		.reboot_i       (reboot_i),
		.reset_button_i (reset_button_i),
		.osd_reset_i    (osd_reset_i),
		.rom_dl_i       (rom_dl),
		.memory_16k_i   (memory_16k_i),
		.reset_o        (reset_o)
	);

endmodule

//--- src/c16_mem_pkg.sv
package c16_mem_pkg;

	// ----------------------------------------------------------
	// sdram request port
	// ----------------------------------------------------------

	// byte address, the sdram itself takes word addresses
	typedef logic [24:0] mem_addr_t;

	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] din;
		logic        we;
		logic        oe;
		logic [1:0]  ds;
	} sdram_req_t;

	// width of the slot phase counter, top bit is clkref
	localparam int SLOT_BITS = 4;

	// ----------------------------------------------------------
	// downloads
	// ----------------------------------------------------------

	typedef enum logic [7:0] {
		DL_ROM_COMBINED = 8'h00,
		DL_PRG          = 8'h01,
		DL_KERNAL       = 8'h03
	} dl_kind_e;

	typedef struct packed {
		logic       active;
		logic [7:0] index;
	} dl_session_t;

	// ----------------------------------------------------------
	// memory map
	// ----------------------------------------------------------

	// rom images live above the 64k of c16 ram
	localparam mem_addr_t ROM_MEM_START = 25'h10000;

	// combined image starts with the 1541 rom, which is not kept here
	localparam mem_addr_t ROM_DL_SKIP = 25'h4000;

endpackage

//--- src/download_injector.sv
`timescale 1ns/1ns

module download_injector (
	input  logic                      clk28,
	input  logic                      pll_locked,
	input  c16_mem_pkg::dl_session_t  dl_session_i,
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  c16_mem_pkg::mem_addr_t    wb_adr_i,
	input  logic [7:0]                wb_dat_i,
	output logic                      wb_ack_o,
	output c16_mem_pkg::sdram_req_t   io_req_o,
	output logic                      prg_end_o,
	output c16_bus_pkg::c16_addr_t    prg_last_addr_o,
	input  logic                      clkref_i
);

	logic                   is_prg, is_kernal, is_combined;
	logic                   needs_write, accept;
	logic                   clkref_q, slot_fall, slot_rise;
	logic                   pending, io_we, prg_q;
	logic [7:0]             hold_data, io_data;
	c16_mem_pkg::mem_addr_t io_addr;

	// ----------------------------------------------------------
	// session and byte decode
	// ----------------------------------------------------------

	assign is_prg      = dl_session_i.active && (dl_session_i.index == c16_mem_pkg::DL_PRG);
	assign is_kernal   = dl_session_i.active && (dl_session_i.index == c16_mem_pkg::DL_KERNAL);
	assign is_combined = dl_session_i.active &&
		(dl_session_i.index == c16_mem_pkg::DL_ROM_COMBINED);

	// prg header bytes and the leading 1541 part are consumed without a write
	always_comb begin
		if (is_prg)
			needs_write = (wb_adr_i > 25'd1);
		else if (is_kernal)
			needs_write = 1'b1;
		else if (is_combined)
			needs_write = (wb_adr_i >= c16_mem_pkg::ROM_DL_SKIP);
		else
			needs_write = 1'b0;
	end

	// hold off while a byte still waits for its io slot
	assign accept = wb_cyc_i && wb_stb_i && wb_we_i && !wb_ack_o &&
		(!pending || !needs_write);

	assign slot_fall = clkref_q && !clkref_i;
	assign slot_rise = !clkref_q && clkref_i;

	// ----------------------------------------------------------
	// holding register and io slot write
	// ----------------------------------------------------------

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			clkref_q  <= 1'b0;
			wb_ack_o  <= 1'b0;
			pending   <= 1'b0;
			io_we     <= 1'b0;
			io_addr   <= '0;
			prg_q     <= 1'b0;
			prg_end_o <= 1'b0;
		end else begin
			clkref_q  <= clkref_i;
			wb_ack_o  <= accept;
			prg_q     <= is_prg;
			prg_end_o <= prg_q && !is_prg;
			// io slot starts, hand the waiting byte over
			if (slot_fall) begin
				io_we   <= pending;
				pending <= 1'b0;
			end
			// c16 slot starts, the io write is done
			if (slot_rise) begin
				if (io_we)
					io_addr <= io_addr + 25'd1;
				io_we <= 1'b0;
			end
			if (accept) begin
				if (needs_write)
					pending <= 1'b1;
				// prg load address is little endian in the first two bytes
				if (is_prg && wb_adr_i == 25'd0)
					io_addr[7:0] <= wb_dat_i;
				if (is_prg && wb_adr_i == 25'd1)
					io_addr[24:8] <= {9'd0, wb_dat_i};
				if ((is_kernal && wb_adr_i == 25'd0) ||
					(is_combined && wb_adr_i == c16_mem_pkg::ROM_DL_SKIP))
					io_addr <= c16_mem_pkg::ROM_MEM_START;
			end
		end
	end

	always_ff @(posedge clk28) begin
		if (accept && needs_write)
			hold_data <= wb_dat_i;
		if (slot_fall && pending)
			io_data <= hold_data;
	end

	assign io_req_o.addr = io_addr[24:1];
	assign io_req_o.din  = {io_data, io_data};
	assign io_req_o.we   = io_we;
	assign io_req_o.oe   = 1'b0;
	assign io_req_o.ds   = {io_addr[0], ~io_addr[0]};

	// bytes still in flight count as written
	assign prg_last_addr_o = io_addr[15:0] + {15'd0, io_we} + {15'd0, pending};

endmodule

//--- src/reset_gen.sv
`timescale 1ns/1ns

module reset_gen #(
	parameter int LONG_RESET_CYCLES  = 28_000_000,
	parameter int SHORT_RESET_CYCLES = 65_536
) (
	input  logic clk28,
	input  logic pll_locked,
	input  logic reboot_i,
	input  logic reset_button_i,
	input  logic osd_reset_i,
	input  logic rom_dl_i,
	input  logic memory_16k_i,
	output logic reset_o
);

	localparam logic [31:0] LONG_LOAD  = LONG_RESET_CYCLES;
	localparam logic [31:0] SHORT_LOAD = SHORT_RESET_CYCLES;

	logic [31:0] reset_cnt;
	logic        reboot_q, last_mem16k;

	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			// long reset on startup
			reset_cnt   <= LONG_LOAD;
			reboot_q    <= 1'b0;
			last_mem16k <= 1'b0;
		end else begin
			reboot_q    <= reboot_i;
			last_mem16k <= memory_16k_i;
			if (reboot_i && !reboot_q)
				reset_cnt <= LONG_LOAD;
			// a short request never cuts a running long reset
			else if (reset_button_i || osd_reset_i || rom_dl_i ||
				(memory_16k_i != last_mem16k))
				reset_cnt <= (reset_cnt > SHORT_LOAD) ? reset_cnt : SHORT_LOAD;
			else if (reset_cnt != 32'd0)
				reset_cnt <= reset_cnt - 32'd1;
		end
	end

	assign reset_o = (reset_cnt != 32'd0);

endmodule

//--- src/sdram_port_mux.sv
`timescale 1ns/1ns

module sdram_port_mux (
	input  logic                    clkref_i,
	input  logic                    memory_16k_i,
	input  c16_bus_pkg::c16_addr_t  cpu_addr_i,
	input  logic                    rom_access_i,
	input  c16_bus_pkg::rom_bank_e  rom_bank_i,
	input  logic [13:0]             rom_addr_i,
	input  logic                    cpu_wr_i,
	input  logic                    cpu_rd_i,
	input  logic [7:0]              cpu_dout_i,
	input  c16_mem_pkg::sdram_req_t io_req_i,
	input  logic                    zp_hit_i,
	input  logic [7:0]              zp_dout_i,
	input  logic [15:0]             sdram_dout_i,
	output c16_mem_pkg::sdram_req_t sdram_req_o,
	output logic [7:0]              c16_din_o
);

	c16_bus_pkg::c16_addr_t  ram_addr;
	c16_mem_pkg::mem_addr_t  rom_byte, c16_byte;
	c16_mem_pkg::sdram_req_t c16_req;

	// 16k machines ignore a7 and a15..a14, so those mirror
	assign ram_addr = memory_16k_i ? (cpu_addr_i & 16'h3f7f) : cpu_addr_i;

	assign rom_byte = c16_mem_pkg::ROM_MEM_START + {9'd0, rom_bank_i, rom_addr_i};
	assign c16_byte = rom_access_i ? rom_byte : {9'd0, ram_addr};

	assign c16_req.addr = c16_byte[24:1];
	assign c16_req.din  = {cpu_dout_i, cpu_dout_i};
	// shadowed zero page bytes never reach the sdram
	assign c16_req.we   = cpu_wr_i && !zp_hit_i;
	assign c16_req.oe   = cpu_rd_i;
	assign c16_req.ds   = {c16_byte[0], ~c16_byte[0]};

	// clkref high is the c16 slot
	assign sdram_req_o = clkref_i ? c16_req : io_req_i;

	always_comb begin
		if (zp_hit_i)
			c16_din_o = zp_dout_i;
		else if (c16_byte[0])
			c16_din_o = sdram_dout_i[15:8];
		else
			c16_din_o = sdram_dout_i[7:0];
	end

endmodule

//--- src/ted_bus_decoder.sv
`timescale 1ns/1ns

module ted_bus_decoder (
	input  logic                                 clk28,
	input  logic                                 pll_locked,
	input  c16_bus_pkg::ted_bus_t                ted_i,
	output c16_bus_pkg::c16_addr_t               cpu_addr_o,
	output logic                                 rom_access_o,
	output c16_bus_pkg::rom_bank_e               rom_bank_o,
	output logic                                 cpu_wr_o,
	output logic                                 cpu_rd_o,
	output logic                                 cas_fall_o,
	output logic [c16_mem_pkg::SLOT_BITS-1:0]    slot_o
);

	logic       ras_q, ras_qq;
	logic       cas_q, cas_qq;
	logic       ras_fall, cas_fall;
	logic [7:0] a_low, a_high;

	assign ras_fall = ras_qq & ~ras_q;
	assign cas_fall = cas_qq & ~cas_q;

	// sample the strobes, the slot phase restarts after every ras edge
	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			ras_q      <= 1'b1;
			ras_qq     <= 1'b1;
			cas_q      <= 1'b1;
			cas_qq     <= 1'b1;
			cas_fall_o <= 1'b0;
			slot_o     <= '0;
		end else begin
			ras_q      <= ted_i.ras_n;
			ras_qq     <= ras_q;
			cas_q      <= ted_i.cas_n;
			cas_qq     <= cas_q;
			// pulse while the freshly latched high byte is valid
			cas_fall_o <= cas_fall;
			if (ras_fall)
				slot_o <= '0;
			else
				slot_o <= slot_o + 1'b1;
		end
	end

	// row and column address bytes
	always_ff @(posedge clk28) begin
		if (ras_fall)
			a_low <= ted_i.a;
		if (cas_fall)
			a_high <= ted_i.a;
	end

	assign cpu_addr_o   = {a_high, a_low};
	assign rom_access_o = (~ted_i.basic_sel_n | ~ted_i.kernal_sel_n) & ted_i.rw;
	assign cpu_wr_o     = ~ted_i.cas_n & ~ted_i.rw;
	assign cpu_rd_o     = (~ted_i.cas_n & ted_i.rw) | rom_access_o;

	// bank from basic select and rom_sel, cartridges fall back to kernal
	always_comb begin
		casez ({ted_i.basic_sel_n, ted_i.rom_sel})
			5'b1_00??: rom_bank_o = c16_bus_pkg::KERNAL;
			5'b1_10??: rom_bank_o = c16_bus_pkg::FUNC_HIGH;
			5'b0_??00: rom_bank_o = c16_bus_pkg::BASIC;
			5'b0_??10: rom_bank_o = c16_bus_pkg::FUNC_LOW;
			default:   rom_bank_o = c16_bus_pkg::KERNAL;
		endcase
	end

endmodule

//--- src/zp_shadow.sv
`timescale 1ns/1ns

module zp_shadow (
	input  logic                   clk28,
	input  logic                   pll_locked,
	input  c16_bus_pkg::c16_addr_t cpu_addr_i,
	input  logic                   rom_access_i,
	input  logic                   cpu_wr_i,
	input  logic                   cas_fall_i,
	input  logic [7:0]             cpu_dout_i,
	input  logic                   prg_end_i,
	input  c16_bus_pkg::c16_addr_t prg_last_addr_i,
	output logic                   zp_hit_o,
	output logic [7:0]             zp_dout_o
);

	localparam int NPTR = c16_bus_pkg::ZP_PTR_NUM;

	c16_bus_pkg::c16_addr_t ptr [NPTR];
	logic [NPTR-1:0]        lo_sel, hi_sel;

	// address compare against the low and high byte of each pointer
	always_comb begin
		for (int i = 0; i < NPTR; i++) begin
			lo_sel[i] = (cpu_addr_i == c16_bus_pkg::ZP_PTR_ADDR[i]);
			hi_sel[i] = (cpu_addr_i == c16_bus_pkg::ZP_PTR_ADDR[i] + 16'd1);
		end
	end

	assign zp_hit_o = !rom_access_i && ((|lo_sel) || (|hi_sel));

	always_comb begin
		zp_dout_o = 8'hff;
		for (int i = 0; i < NPTR; i++) begin
			if (lo_sel[i])
				zp_dout_o = ptr[i][7:0];
			if (hi_sel[i])
				zp_dout_o = ptr[i][15:8];
		end
	end

	// basic end pointers follow the injected program, cpu may overwrite them
	always_ff @(posedge clk28 or negedge pll_locked) begin
		if (!pll_locked) begin
			for (int i = 0; i < NPTR; i++)
				ptr[i] <= '0;
		end else if (prg_end_i) begin
			for (int i = 0; i < NPTR; i++)
				ptr[i] <= prg_last_addr_i;
		end else if (cas_fall_i && cpu_wr_i && zp_hit_o) begin
			for (int i = 0; i < NPTR; i++) begin
				if (lo_sel[i])
					ptr[i][7:0] <= cpu_dout_i;
				if (hi_sel[i])
					ptr[i][15:8] <= cpu_dout_i;
			end
		end
	end

endmodule

//--- testbench/c16_mem_glue_assert.sv
`timescale 1ns/1ns

module c16_mem_glue_assert (
	input logic                    clk28,
	input logic                    pll_locked,
	input c16_mem_pkg::sdram_req_t sdram_req_i,
	input c16_mem_pkg::sdram_req_t io_req_i,
	input logic                    clkref_i,
	input logic                    wb_stb_i,
	input logic                    wb_ack_i
);

	// the sdram gets a read or a write, never both
	req_excl: assert property (@(posedge clk28) disable iff (!pll_locked)
		!(sdram_req_i.we && sdram_req_i.oe))
		else $error("sdram request with we and oe high together");

	// classic cycle, ack only while the host strobes
	ack_in_stb: assert property (@(posedge clk28) disable iff (!pll_locked)
		wb_ack_i |-> wb_stb_i)
		else $error("wishbone ack without stb");

	// io writes start inside the io slot
	io_in_slot: assert property (@(posedge clk28) disable iff (!pll_locked)
		$rose(io_req_i.we) |-> !clkref_i)
		else $error("io write started in the c16 slot");

endmodule

bind c16_mem_glue c16_mem_glue_assert u_mem_glue_assert (
	.clk28       (clk28),
	.pll_locked  (pll_locked),
	.sdram_req_i (sdram_req_o),
	.io_req_i    (io_req),
	.clkref_i    (clkref_o),
	.wb_stb_i    (wb_stb_i),
	.wb_ack_i    (wb_ack_o)
);

//--- testbench/tb_c16_mem_glue.sv
`timescale 1ns/1ns

module tb_c16_mem_glue;

	localparam int LONG_CYC  = 40;
	localparam int SHORT_CYC = 20;
	localparam int TMO       = 64;

	logic                    clk28, pll_locked, c16_wait, reset_o, memory_16k;
	logic                    reboot, reset_button, osd_reset, clkref, clkref_prev;
	logic                    wb_cyc, wb_stb, wb_we, wb_ack, last_needed_write;
	logic [7:0]              c16_din, wb_dat;
	logic [15:0]             sdram_dout;
	logic [24:0]             wb_adr;
	c16_bus_pkg::ted_bus_t   ted;
	c16_mem_pkg::dl_session_t dl_session;
	c16_mem_pkg::sdram_req_t sdram_req;
	logic [15:0]             sdram_mem [0:131071];
	logic [7:0]              dl_data [$];
	int                      ack_count = 0;
	int                      clkref_falls = 0;
	int                      zp_writes = 0;
	int                      bytes_sent, falls_at_ack;
	integer                  seed;

	c16_mem_glue #(.LONG_RESET_CYCLES(LONG_CYC), .SHORT_RESET_CYCLES(SHORT_CYC)) dut (
		.clk28(clk28), .pll_locked(pll_locked), .ted_i(ted), .c16_din_o(c16_din),
		.c16_wait_o(c16_wait), .reset_o(reset_o), .memory_16k_i(memory_16k),
		.reboot_i(reboot), .reset_button_i(reset_button), .osd_reset_i(osd_reset),
		.dl_session_i(dl_session), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_ack_o(wb_ack), .sdram_req_o(sdram_req),
		.sdram_dout_i(sdram_dout), .clkref_o(clkref)
	);

	initial clk28 = 1'b0;
	always #5 clk28 = ~clk28;

	// ----------------------------------------------------------
	// sdram model and bus monitors
	// ----------------------------------------------------------

	always @(posedge clk28) begin
		if (sdram_req.we) begin
			if (sdram_req.ds[0])
				sdram_mem[sdram_req.addr[16:0]][7:0] <= sdram_req.din[7:0];
			if (sdram_req.ds[1])
				sdram_mem[sdram_req.addr[16:0]][15:8] <= sdram_req.din[15:8];
			// $2e is the low byte of word $17
			if (sdram_req.addr == 24'h17 && sdram_req.ds[0])
				zp_writes++;
		end
		if (sdram_req.oe)
			sdram_dout <= sdram_mem[sdram_req.addr[16:0]];
		if (wb_ack)
			ack_count++;
		if (clkref_prev && !clkref)
			clkref_falls++;
		clkref_prev <= clkref;
	end

	function automatic logic [7:0] model_byte(input logic [24:0] a);
		logic [15:0] w;
		w = sdram_mem[a[17:1]];
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	task automatic stop_failed();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			stop_failed();
		end
	endtask

	task automatic wait_clkref(input logic level);
		int n;
		n = 0;
		while (clkref !== level) begin
			@(negedge clk28);
			n++;
			if (n > TMO) begin
				$display("timeout while waiting for clkref to reach %0d", level);
				stop_failed();
			end
		end
	endtask

	task automatic wait_reset_low(input int min_cyc, input int max_cyc, input string what);
		int n;
		n = 0;
		while (reset_o) begin
			@(negedge clk28);
			n++;
			if (n > max_cyc) begin
				$display("reset_o stayed high too long %s", what);
				stop_failed();
			end
		end
		if (n < min_cyc) begin
			$display("reset_o fell after %0d cycles %s", n, what);
			stop_failed();
		end
	endtask

	// ----------------------------------------------------------
	// directed tasks
	// ----------------------------------------------------------

	task automatic reset_dut();
		pll_locked = 1'b0;
		repeat (16) @(negedge clk28);
		check("reset_o", reset_o, 1);
		pll_locked = 1'b1;
		wait_reset_low(LONG_CYC - 2, LONG_CYC + 2, "after pll lock");
		@(negedge clk28);
		reset_button = 1'b1;
		repeat (3) @(negedge clk28);
		check("reset_o", reset_o, 1);
		reset_button = 1'b0;
		wait_reset_low(SHORT_CYC - 2, SHORT_CYC + 2, "after the reset button");
	endtask

	// one ras/cas frame, row byte first, column byte two cycles later
	task automatic ted_frame(input logic [15:0] addr, input logic rw, input logic [7:0] wdat,
		output logic [7:0] rdat);
		@(negedge clk28);
		ted.a = addr[7:0];
		ted.ras_n = 1'b0;
		repeat (2) @(negedge clk28);
		ted.a = addr[15:8];
		ted.rw = rw;
		ted.dout = wdat;
		ted.cas_n = 1'b0;
		wait_clkref(1'b1);
		repeat (4) @(negedge clk28);
		rdat = c16_din;
		wait_clkref(1'b0);
		ted.ras_n = 1'b1;
		ted.cas_n = 1'b1;
		ted.rw = 1'b1;
	endtask

	task automatic ted_write(input logic [15:0] addr, input logic [7:0] wdat);
		logic [7:0] unused;
		ted_frame(addr, 1'b0, wdat, unused);
	endtask

	task automatic ted_read(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] rdat;
		ted_frame(addr, 1'b1, 8'h00, rdat);
		check($sformatf("c16_din_o at %h", addr), rdat, exp);
	endtask

	task automatic rom_fetch(input logic [13:0] raddr, input logic [7:0] exp);
		@(negedge clk28);
		ted.rom_addr = raddr;
		ted.rom_sel = 4'b0000;
		ted.kernal_sel_n = 1'b0;
		wait_clkref(1'b0);
		wait_clkref(1'b1);
		repeat (4) @(negedge clk28);
		check($sformatf("c16_din_o kernal %h", raddr), c16_din, exp);
		ted.kernal_sel_n = 1'b1;
	endtask

	task automatic wb_write_byte(input logic [24:0] adr, input logic [7:0] dat,
		input logic need_write);
		int n;
		@(negedge clk28);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat = dat;
		n = 0;
		while (!wb_ack) begin
			@(negedge clk28);
			n++;
			if (n > TMO) begin
				$display("no wishbone ack for download offset %h", adr);
				stop_failed();
			end
		end
		// a full holding register only empties at a falling clkref
		if (need_write && last_needed_write && clkref_falls == falls_at_ack) begin
			$display("byte at offset %h acked while the holding register was full", adr);
			stop_failed();
		end
		falls_at_ack = clkref_falls;
		last_needed_write = need_write;
		@(negedge clk28);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		bytes_sent++;
	endtask

	task automatic download_file(input logic [7:0] kind, input logic [15:0] load, input int n);
		int acks_before, off;
		logic [7:0] dat;
		logic [24:0] base;
		acks_before = ack_count;
		bytes_sent = 0;
		last_needed_write = 1'b0;
		dl_data.delete();
		@(negedge clk28);
		dl_session.index = kind;
		dl_session.active = 1'b1;
		@(negedge clk28);
		check("c16_wait_o", c16_wait, 1);
		off = 0;
		base = c16_mem_pkg::ROM_MEM_START;
		if (kind == c16_mem_pkg::DL_PRG) begin
			wb_write_byte(25'd0, load[7:0], 1'b0);
			wb_write_byte(25'd1, load[15:8], 1'b0);
			off = 2;
			base = {9'd0, load};
		end else begin
			check("reset_o", reset_o, 1);
		end
		for (int i = 0; i < n; i++) begin
			dat = 8'($random(seed));
			dl_data.push_back(dat);
			wb_write_byte(25'(off + i), dat, 1'b1);
		end
		// last byte needs one more io slot
		wait_clkref(1'b1);
		wait_clkref(1'b0);
		wait_clkref(1'b1);
		@(negedge clk28);
		dl_session.active = 1'b0;
		repeat (4) @(negedge clk28);
		check("wb_ack_o count", ack_count - acks_before, bytes_sent);
		for (int i = 0; i < n; i++)
			check($sformatf("sdram byte %h", base + 25'(i)),
				model_byte(base + 25'(i)), dl_data[i]);
	endtask

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------

	initial begin
		logic [7:0]  wdat [8];
		logic [15:0] a, end_addr;
		seed = 32'hc9a8;
		for (int i = 0; i < 131072; i++)
			sdram_mem[i] = 16'(i) ^ {15'd0, i[16]} ^ 16'hc3a5;
		ted = '{ras_n: 1'b1, cas_n: 1'b1, rw: 1'b1, basic_sel_n: 1'b1, kernal_sel_n: 1'b1,
			default: '0};
		pll_locked = 1'b0;
		memory_16k = 1'b0;
		reboot = 1'b0;
		reset_button = 1'b0;
		osd_reset = 1'b0;
		dl_session = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat = '0;
		sdram_dout = '0;
		clkref_prev = 1'b0;
		falls_at_ack = 0;
		last_needed_write = 1'b0;
		reset_dut();

		// 64k ram path
		for (int i = 0; i < 8; i++) begin
			wdat[i] = 8'($random(seed));
			ted_write(16'h1200 + 16'(i) * 16'h0101, wdat[i]);
		end
		for (int i = 0; i < 8; i++)
			ted_read(16'h1200 + 16'(i) * 16'h0101, wdat[i]);

		// 16k mapping mirrors a7, a14 and a15
		memory_16k = 1'b1;
		for (int i = 0; i < 4; i++) begin
			a = 16'h0a40 + 16'(i) * 16'd3;
			wdat[i] = 8'($random(seed));
			ted_write(a | 16'hc080, wdat[i]);
			ted_read(a, wdat[i]);
			ted_read(a | 16'h0080, wdat[i]);
			ted_read(a | 16'h4000, wdat[i]);
			ted_read(a | 16'h8000, wdat[i]);
		end
		memory_16k = 1'b0;

		// prg injection, then the shadow pointers
		download_file(c16_mem_pkg::DL_PRG, 16'h1001, 12);
		end_addr = 16'h1001 + 16'd12;
		ted_read(16'h002d, end_addr[7:0]);
		ted_read(16'h002e, end_addr[15:8]);
		ted_read(16'h002f, end_addr[7:0]);
		ted_read(16'h0030, end_addr[15:8]);
		ted_read(16'h0031, end_addr[7:0]);
		ted_read(16'h0032, end_addr[15:8]);
		ted_read(16'h009d, end_addr[7:0]);
		ted_read(16'h009e, end_addr[15:8]);
		ted_write(16'h002e, 8'h5c);
		ted_read(16'h002e, 8'h5c);
		check("sdram writes at 002e", zp_writes, 0);

		// kernal image and rom fetch
		wait_reset_low(0, SHORT_CYC + 2 + TMO, "before the rom download");
		download_file(c16_mem_pkg::DL_KERNAL, 16'h0000, 8);
		for (int i = 0; i < 8; i++)
			rom_fetch(14'(i), dl_data[i]);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
